// ==== alu/core_alu.sv ====
`default_nettype none

module core_alu
	import exe_pkg::*;
(
	input  word_t      src1,
	input  word_t      src2,
	input  alu_op_e    alu_op,
	input  brnch_cnd_e brnch_cnd,
	output word_t      alu_result,
	output logic       brnch_taken
);

	logic [shamt_w_c-1:0] shamt;
	logic                 is_eq;
	logic                 lt_s;
	logic                 lt_u;

	assign shamt = src2[shamt_w_c-1:0];
	assign is_eq = (src1 == src2);
	assign lt_s  = ($signed(src1) < $signed(src2));
	assign lt_u  = (src1 < src2);

	// ============================================================
	// Arithmetic, logic and shifts
	// ============================================================
	always_comb begin
		case (alu_op)
			alu_add:    alu_result = src1 + src2;
			alu_sub:    alu_result = src1 - src2;
			alu_sll:    alu_result = src1 << shamt;
			alu_slt:    alu_result = word_t'(lt_s);
			alu_sltu:   alu_result = word_t'(lt_u);
			alu_xor:    alu_result = src1 ^ src2;
			alu_srl:    alu_result = src1 >> shamt;
			alu_sra:    alu_result = word_t'($signed(src1) >>> shamt);
			alu_or:     alu_result = src1 | src2;
			alu_and:    alu_result = src1 & src2;
			alu_pass_b: alu_result = src2;
			default:    alu_result = '0;
		endcase
	end

	// ============================================================
	// Branch condition
	// ============================================================
	always_comb begin
		case (brnch_cnd)
			brnch_eq:  brnch_taken = is_eq;
			brnch_ne:  brnch_taken = !is_eq;
			brnch_lt:  brnch_taken = lt_s;
			brnch_ge:  brnch_taken = !lt_s;
			brnch_ltu: brnch_taken = lt_u;
			brnch_geu: brnch_taken = !lt_u;
			default:   brnch_taken = 1'b0;
		endcase
	end

	// Opcode must be one of the encoded operations
	always_comb begin
		a_alu_op_legal: assert ($isunknown(alu_op) || alu_op inside {
			alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
			alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
		}) else $error("core_alu: undefined alu_op %0h", alu_op);
	end

endmodule

`default_nettype wire

// ==== bench/exe_ref_model.svh ====
`ifndef exe_ref_model_svh
`define exe_ref_model_svh

// Signed less-than from the sign bits, unsigned compare when they agree
function automatic logic signed_less(input word_t a, input word_t b);
	if (a[31] != b[31])
		return a[31];
	return a < b;
endfunction

function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
	logic [4:0] sh;
	sh = b[4:0];
	case (op)
		alu_add:    return a + b;
		alu_sub:    return a + ~b + 32'd1;
		alu_sll:    return a << sh;
		alu_slt:    return {31'b0, signed_less(a, b)};
		alu_sltu:   return {31'b0, a < b};
		alu_xor:    return a ^ b;
		alu_srl:    return a >> sh;
		alu_sra:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
		alu_or:     return a | b;
		alu_and:    return a & b;
		alu_pass_b: return b;
		default:    return 32'h0;
	endcase
endfunction

function automatic logic branch_model(input brnch_cnd_e cnd, input word_t a, input word_t b);
	case (cnd)
		brnch_eq:  return a == b;
		brnch_ne:  return a != b;
		brnch_lt:  return signed_less(a, b);
		brnch_ge:  return !signed_less(a, b);
		brnch_ltu: return a < b;
		brnch_geu: return a >= b;
		default:   return 1'b0;
	endcase
endfunction

// Register 0 reads zero, then memory stage, then writeback, then register file
function automatic word_t operand_model(input reg_idx_t rs, input word_t rf, input fwd_t m,
		input fwd_t w);
	if (rs == 5'd0)
		return 32'h0;
	if (m.valid && m.rd == rs)
		return m.value;
	if (w.valid && w.rd == rs)
		return w.value;
	return rf;
endfunction

function automatic exe_res_t expected_result(input exe_op_t op, input fwd_t m, input fwd_t w);
	exe_res_t res;
	word_t    r1;
	word_t    r2;
	r1 = operand_model(op.rs1, op.rs1_val, m, w);
	r2 = operand_model(op.rs2, op.rs2_val, m, w);
	res.alu_result = alu_model(op.alu_op, (op.src_a_sel == src_a_pc) ? op.pc : r1,
		(op.src_b_sel == src_b_imm) ? op.imm : r2);
	res.brnch_taken = branch_model(op.brnch_cnd, r1, r2);
	res.pc_4 = op.pc + 32'd4;
	if (op.addr_base == addr_rs1)
		res.addr = r1 + op.imm;
	else if (op.addr_base == addr_pc_4)
		res.addr = op.pc + 32'd4 + op.imm;
	else
		res.addr = op.pc + op.imm;
	res.w_data = r2;
	res.rd = op.rd;
	return res;
endfunction

`endif

// ==== bench/exe_tb.sv ====
`default_nettype none

module exe_tb
	import exe_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Six tests, 143 micro-ops in all
	localparam int total_ops_c = 143;
	localparam int wd_cycles_c = total_ops_c * 20 + 100;

	logic     clk = 1'b0;
	logic     reset;
	logic     kill;
	logic     in_valid;
	logic     in_ready;
	exe_op_t  in_op;
	fwd_t     fwd_m;
	fwd_t     fwd_w;
	logic     out_valid;
	logic     out_ready;
	exe_res_t out_res;

	exe_res_t exp_q[$];
	int       acc_q[$];
	int       cyc = 0;
	int       last_acc = 0;
	int       errors = 0;
	int       checks = 0;
	int       mon_errors = 0;
	int       mon_checks = 0;
	logic     check_latency = 1'b0;
	logic     stalled = 1'b0;
	exe_res_t held_res;

	`include "exe_ref_model.svh"

	exe_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.kill     (kill),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_op    (in_op),
		.fwd_m    (fwd_m),
		.fwd_w    (fwd_w),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res  (out_res)
	);

	always #2 clk = ~clk;

	always @(negedge clk) cyc <= cyc + 1;

	// ============================================================
	// Output monitor and scoreboard
	// ============================================================
	always @(posedge clk) begin
		exe_res_t exp_res;
		int       acc;
		if (reset || kill) begin
			stalled = 1'b0;
		end else begin
			if (stalled) begin
				mon_checks++;
				assert (out_res === held_res) else begin
					mon_errors++;
					$display("CHECK FAILED @%0t: out_res changed while stalled", $time);
				end
			end
			stalled = out_valid && !out_ready;
			held_res = out_res;
			if (out_valid && out_ready) begin
				mon_checks++;
				assert (exp_q.size() != 0) else begin
					mon_errors++;
					$display("Error @%0t: a result left the stage with nothing outstanding",
						$time);
				end
				if (exp_q.size() != 0) begin
					exp_res = exp_q.pop_front();
					acc = acc_q.pop_front();
					assert (out_res === exp_res) else begin
						mon_errors++;
						$display("CHECK FAILED @%0t: out_res %h, expected %h", $time,
							out_res, exp_res);
					end
					if (check_latency) begin
						assert (cyc - acc == 2) else begin
							mon_errors++;
							$display("CHECK FAILED @%0t: latency %0d cycles, expected 2",
								$time, cyc - acc);
						end
					end
				end
			end
		end
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================
	function automatic exe_op_t rand_op(input alu_op_e alu_op);
		exe_op_t op;
		op.pc        = $urandom & 32'hffff_fffc;
		op.rs1_val   = $urandom;
		op.rs2_val   = $urandom;
		op.rs1       = reg_idx_t'($urandom);
		op.rs2       = reg_idx_t'($urandom);
		op.rd        = reg_idx_t'($urandom);
		op.imm       = $urandom;
		op.alu_op    = alu_op;
		op.brnch_cnd = brnch_none;
		op.src_a_sel = (($urandom & 1) != 0) ? src_a_pc : src_a_rs1;
		op.src_b_sel = (($urandom & 1) != 0) ? src_b_imm : src_b_rs2;
		op.addr_base = addr_base_e'($urandom % 3);
		return op;
	endfunction

	function automatic fwd_t fwd_bus(input logic valid, input reg_idx_t rd, input word_t value);
		fwd_t bus;
		bus.valid = valid;
		bus.rd    = rd;
		bus.value = value;
		return bus;
	endfunction

	// Holds the op until accepted; the expected result is queued only when keep is set
	task automatic send_op(input exe_op_t op, input logic keep);
		@(negedge clk);
		in_valid = 1'b1;
		in_op = op;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		last_acc = cyc;
		if (keep) begin
			exp_q.push_back(expected_result(op, fwd_m, fwd_w));
			acc_q.push_back(cyc);
		end
	endtask

	task automatic drain();
		@(negedge clk);
		in_valid = 1'b0;
		out_ready = 1'b1;
		while (exp_q.size() != 0 || out_valid)
			@(negedge clk);
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic alu_test();
		int rep;
		int k;
		checks++;
		assert (!out_valid && in_ready) else begin
			errors++;
			$display("CHECK FAILED @%0t: out_valid/in_ready wrong after reset", $time);
		end
		for (rep = 0; rep < 4; rep++)
			for (k = 0; k <= 10; k++)
				send_op(rand_op(alu_op_e'(k)), 1'b1);
		drain();
	endtask

	task automatic branch_test();
		word_t   a_vals[5];
		word_t   b_vals[5];
		exe_op_t op;
		int      c;
		int      p;
		a_vals = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};
		b_vals = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
		for (c = 0; c <= 6; c++) begin
			for (p = 0; p < 5; p++) begin
				op = rand_op(alu_sub);
				op.rs1 = 5'd1;
				op.rs2 = 5'd2;
				op.rs1_val = a_vals[p];
				op.rs2_val = b_vals[p];
				op.brnch_cnd = brnch_cnd_e'(c);
				op.addr_base = addr_base_e'((c + p) % 3);
				send_op(op, 1'b1);
			end
		end
		drain();
	endtask

	task automatic fwd_case(input reg_idx_t rs1, input reg_idx_t rs2, input fwd_t m,
			input fwd_t w);
		exe_op_t op;
		op = rand_op(alu_add);
		op.rs1 = rs1;
		op.rs2 = rs2;
		op.src_a_sel = src_a_rs1;
		op.src_b_sel = src_b_rs2;
		op.addr_base = addr_rs1;
		@(negedge clk);
		fwd_m = m;
		fwd_w = w;
		send_op(op, 1'b1);
		drain();
	endtask

	task automatic fwd_test();
		fwd_case(5'd3, 5'd4, fwd_bus(1'b1, 5'd3, 32'h1111_0001),
			fwd_bus(1'b1, 5'd3, 32'h2222_0001));
		fwd_case(5'd3, 5'd4, fwd_bus(1'b1, 5'd9, 32'h1111_0002),
			fwd_bus(1'b1, 5'd4, 32'h2222_0002));
		fwd_case(5'd4, 5'd4, fwd_bus(1'b1, 5'd4, 32'h1111_0003),
			fwd_bus(1'b1, 5'd4, 32'h2222_0003));
		fwd_case(5'd0, 5'd0, fwd_bus(1'b1, 5'd0, 32'h1111_0004),
			fwd_bus(1'b1, 5'd0, 32'h2222_0004));
		fwd_case(5'd5, 5'd6, fwd_bus(1'b0, 5'd5, 32'h1111_0005),
			fwd_bus(1'b1, 5'd5, 32'h2222_0005));
		fwd_case(5'd7, 5'd8, fwd_bus(1'b0, 5'd7, 32'h1111_0006),
			fwd_bus(1'b0, 5'd8, 32'h2222_0006));
		@(negedge clk);
		fwd_m = '0;
		fwd_w = '0;
	endtask

	task automatic stall_test();
		int   n;
		logic done;
		done = 1'b0;
		fork
			begin
				for (n = 0; n < 30; n++)
					send_op(rand_op(alu_op_e'($urandom % 11)), 1'b1);
				done = 1'b1;
			end
			begin
				while (!done) begin
					@(negedge clk);
					out_ready = ($urandom & 1) != 0;
				end
			end
		join
		drain();
	endtask

	task automatic kill_test();
		int n;
		@(negedge clk);
		out_ready = 1'b0;
		// Both of these are flushed before they can leave
		send_op(rand_op(alu_add), 1'b0);
		send_op(rand_op(alu_xor), 1'b0);
		@(negedge clk);
		in_valid = 1'b1;
		in_op = rand_op(alu_or);
		kill = 1'b1;
		@(negedge clk);
		kill = 1'b0;
		in_valid = 1'b0;
		@(posedge clk);
		checks++;
		assert (!out_valid && in_ready) else begin
			errors++;
			$display("CHECK FAILED @%0t: stage not empty after kill", $time);
		end
		// A request under kill is refused even when the buffer is empty
		@(negedge clk);
		in_valid = 1'b1;
		in_op = rand_op(alu_and);
		kill = 1'b1;
		@(posedge clk);
		checks++;
		assert (!in_ready) else begin
			errors++;
			$display("CHECK FAILED @%0t: in_ready high while kill was high", $time);
		end
		@(negedge clk);
		kill = 1'b0;
		in_valid = 1'b0;
		out_ready = 1'b1;
		for (n = 0; n < 4; n++)
			send_op(rand_op(alu_sub), 1'b1);
		drain();
	endtask

	task automatic stream_test();
		int n;
		int first;
		first = 0;
		check_latency = 1'b1;
		for (n = 0; n < 20; n++) begin
			send_op(rand_op(alu_op_e'($urandom % 11)), 1'b1);
			if (n == 0)
				first = last_acc;
		end
		checks++;
		assert (last_acc - first == 19) else begin
			errors++;
			$display("CHECK FAILED @%0t: 20 ops took %0d cycles to accept", $time,
				last_acc - first + 1);
		end
		drain();
		check_latency = 1'b0;
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		void'($urandom(32'h5f0613f1));
		reset = 1'b1;
		kill = 1'b0;
		in_valid = 1'b0;
		in_op = '0;
		fwd_m = '0;
		fwd_w = '0;
		out_ready = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		alu_test();
		branch_test();
		fwd_test();
		stall_test();
		kill_test();
		stream_test();
		$display("Checks: %0d, errors: %0d", checks + mon_checks, errors + mon_errors);
		if (errors + mon_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		repeat (wd_cycles_c) @(posedge clk);
		$display("Watchdog expired: the run did not finish within %0d cycles", wd_cycles_c);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int xlen_c      = 32;
	localparam int reg_idx_w_c = 5;
	localparam int shamt_w_c   = 5;
	localparam int pc_step_c   = 4;

	typedef logic [xlen_c-1:0]      word_t;
	typedef logic [reg_idx_w_c-1:0] reg_idx_t;

	// ============================================================
	// Control encodings
	// ============================================================
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	typedef enum logic [2:0] {
		brnch_none = 3'd0,
		brnch_eq   = 3'd1,
		brnch_ne   = 3'd2,
		brnch_lt   = 3'd3,
		brnch_ge   = 3'd4,
		brnch_ltu  = 3'd5,
		brnch_geu  = 3'd6
	} brnch_cnd_e;

	typedef enum logic {
		src_a_rs1 = 1'b0,
		src_a_pc  = 1'b1
	} src_a_sel_e;

	typedef enum logic {
		src_b_rs2 = 1'b0,
		src_b_imm = 1'b1
	} src_b_sel_e;

	// Base for loads, stores and jumps
	typedef enum logic [1:0] {
		addr_pc   = 2'd0,
		addr_rs1  = 2'd1,
		addr_pc_4 = 2'd2
	} addr_base_e;

	// ============================================================
	// Bundles
	// ============================================================
	typedef struct packed {
		word_t      pc;
		word_t      rs1_val;
		word_t      rs2_val;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		reg_idx_t   rd;
		word_t      imm;
		alu_op_e    alu_op;
		brnch_cnd_e brnch_cnd;
		src_a_sel_e src_a_sel;
		src_b_sel_e src_b_sel;
		addr_base_e addr_base;
	} exe_op_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    value;
	} fwd_t;

	typedef struct packed {
		word_t    alu_result;
		logic     brnch_taken;
		word_t    addr;
		word_t    w_data;
		word_t    pc_4;
		reg_idx_t rd;
	} exe_res_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+bench
common/exe_pkg.sv
src/exe_issue_buf.sv
src/operand_fwd.sv
alu/core_alu.sv
src/core_exe_s.sv
src/exe_top.sv
bench/exe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 -f files.f --top-module exe_tb -o exe_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/exe_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$log"; then
	exit 1
fi

exit 0

// ==== src/core_exe_s.sv ====
`default_nettype none

module core_exe_s
	import exe_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  wire      kill,

	input  wire      op_valid,
	output logic     op_ready,
	input  exe_op_t  op,

	input  fwd_t     fwd_m,
	input  fwd_t     fwd_w,

	output logic     out_valid,
	input  wire      out_ready,
	output exe_res_t out_res
);

	word_t    rs1_fwd;
	word_t    rs2_fwd;
	word_t    alu_src1;
	word_t    alu_src2;
	word_t    alu_result;
	logic     brnch_taken;
	word_t    pc_4;
	word_t    addr_base;
	exe_res_t res_d;

	// ============================================================
	// Operands
	// ============================================================
	operand_fwd fwd_i (
		.op   (op),
		.fwd_m(fwd_m),
		.fwd_w(fwd_w),
		.src1 (rs1_fwd),
		.src2 (rs2_fwd)
	);

	assign alu_src1 = (op.src_a_sel == src_a_pc)  ? op.pc  : rs1_fwd;
	assign alu_src2 = (op.src_b_sel == src_b_imm) ? op.imm : rs2_fwd;

	// Result path on the selected operands
	core_alu alu_i (
		.src1       (alu_src1),
		.src2       (alu_src2),
		.alu_op     (op.alu_op),
		.brnch_cnd  (brnch_none),
		.alu_result (alu_result),
		.brnch_taken()
	);

	// Compare path always sees rs1 against rs2
	core_alu cmp_i (
		.src1       (rs1_fwd),
		.src2       (rs2_fwd),
		.alu_op     (alu_sub),
		.brnch_cnd  (op.brnch_cnd),
		.alu_result (),
		.brnch_taken(brnch_taken)
	);

	// ============================================================
	// Address
	// ============================================================
	assign pc_4 = op.pc + word_t'(pc_step_c);

	always_comb begin
		case (op.addr_base)
			addr_rs1:  addr_base = rs1_fwd;
			addr_pc_4: addr_base = pc_4;
			default:   addr_base = op.pc;
		endcase
	end

	always_comb begin
		res_d.alu_result  = alu_result;
		res_d.brnch_taken = brnch_taken;
		res_d.addr        = addr_base + op.imm;
		res_d.w_data      = rs2_fwd;
		res_d.pc_4        = pc_4;
		res_d.rd          = op.rd;
	end

	// ============================================================
	// Result register
	// ============================================================
	assign op_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (reset || kill) begin
			out_valid <= 1'b0;
		end else if (op_ready) begin
			out_valid <= op_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid && op_ready) begin
			out_res <= res_d;
		end
	end

	a_out_res_stalled: assert property (
		@(posedge clk) disable iff (reset || kill)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_res))
	) else $error("core_exe_s: out_res moved while stalled");

endmodule

`default_nettype wire

// ==== src/exe_issue_buf.sv ====
`default_nettype none

module exe_issue_buf
	import exe_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     kill,

	input  wire     in_valid,
	output logic    in_ready,
	input  exe_op_t in_op,

	output logic    buf_valid,
	input  wire     buf_ready,
	output exe_op_t buf_op
);

	logic buf_free;

	// Slot opens when empty or when the stage drains it this cycle
	assign buf_free = !buf_valid || buf_ready;
	assign in_ready = buf_free && !kill;

	always_ff @(posedge clk) begin
		if (reset || kill) begin
			buf_valid <= 1'b0;
		end else if (buf_free) begin
			buf_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			buf_op <= in_op;
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	// Source must hold the op until it is taken
	a_in_op_held: assert property (
		@(posedge clk) disable iff (reset || kill)
		(in_valid && !in_ready) |=> $stable(in_op)
	) else $error("exe_issue_buf: in_op changed while stalled");

endmodule

`default_nettype wire

// ==== src/exe_top.sv ====
`default_nettype none

module exe_top
	import exe_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  wire      kill,

	input  wire      in_valid,
	output logic     in_ready,
	input  exe_op_t  in_op,

	input  fwd_t     fwd_m,
	input  fwd_t     fwd_w,

	output logic     out_valid,
	input  wire      out_ready,
	output exe_res_t out_res
);

	logic    buf_valid;
	logic    buf_ready;
	exe_op_t buf_op;

	exe_issue_buf issue_i (
		.clk      (clk),
		.reset    (reset),
		.kill     (kill),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_op    (in_op),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready),
		.buf_op   (buf_op)
	);

	core_exe_s exe_i (
		.clk      (clk),
		.reset    (reset),
		.kill     (kill),
		.op_valid (buf_valid),
		.op_ready (buf_ready),
		.op       (buf_op),
		.fwd_m    (fwd_m),
		.fwd_w    (fwd_w),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res  (out_res)
	);

endmodule

`default_nettype wire

// ==== src/operand_fwd.sv ====
`default_nettype none

module operand_fwd
	import exe_pkg::*;
(
	input  exe_op_t op,
	input  fwd_t    fwd_m,
	input  fwd_t    fwd_w,
	output word_t   src1,
	output word_t   src2
);

	// Memory stage is younger, so it wins over writeback
	function automatic word_t pick(
		input reg_idx_t rs,
		input word_t    rf_val,
		input fwd_t     m,
		input fwd_t     w
	);
		word_t val;
		if (rs == '0) begin
			val = '0;
		end else if (m.valid && (m.rd == rs)) begin
			val = m.value;
		end else if (w.valid && (w.rd == rs)) begin
			val = w.value;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	assign src1 = pick(op.rs1, op.rs1_val, fwd_m, fwd_w);
	assign src2 = pick(op.rs2, op.rs2_val, fwd_m, fwd_w);

endmodule

`default_nettype wire
